// File: source/bpu_pkg.sv
package bpu_pkg;

    //////////////////////////////////////////////////
    // basic widths
    //////////////////////////////////////////////////

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    // primary opcode, inst[31:26]
    typedef logic [5:0]  opcode_t;

    // branch opcodes are 0x12 .. 0x1b inclusive
    localparam opcode_t branch_opcode_lo = 6'h12;
    localparam opcode_t branch_opcode_hi = 6'h1b;

    // two-bit counter states, msb set means taken
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } counter_e;

    //////////////////////////////////////////////////
    // back end to fetch
    //////////////////////////////////////////////////

    typedef struct packed {
        logic  update_en;
        logic  flush;
        addr_t pc;
        logic  taken;
        addr_t target;
    } branch_update_t;

    // per-packet prediction result
    typedef struct packed {
        logic  is_branch_1;
        logic  is_branch_2;
        logic  taken;
        addr_t target;
        logic  slot_2_en;
        logic  valid_in;
    } prediction_t;

endpackage

// File: source/bht.sv
`timescale 1ns/1ps

module bht #(
    parameter int BHT_ENTRIES = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  bpu_pkg::addr_t          pc,
    input  bpu_pkg::branch_update_t update,
    output logic                    taken
);

    localparam int IDX_W = $clog2(BHT_ENTRIES);

    bpu_pkg::counter_e counters [BHT_ENTRIES];

    logic [IDX_W-1:0]  rd_idx;
    logic [IDX_W-1:0]  upd_idx;
    bpu_pkg::counter_e rd_counter;
    bpu_pkg::counter_e upd_counter;
    bpu_pkg::counter_e next_counter;

    // word index, bits [1:0] are always zero
    assign rd_idx  = pc[IDX_W+1:2];
    assign upd_idx = update.pc[IDX_W+1:2];

    assign rd_counter = counters[rd_idx];
    assign taken      = (rd_counter == bpu_pkg::weak_taken) ||
                        (rd_counter == bpu_pkg::strong_taken);

    // saturating step toward the resolved direction
    always_comb begin
        upd_counter = counters[upd_idx];
        case (upd_counter)
            bpu_pkg::strong_not_taken: begin
                next_counter = update.taken ? bpu_pkg::weak_not_taken
                                            : bpu_pkg::strong_not_taken;
            end
            bpu_pkg::weak_not_taken: begin
                next_counter = update.taken ? bpu_pkg::weak_taken
                                            : bpu_pkg::strong_not_taken;
            end
            bpu_pkg::weak_taken: begin
                next_counter = update.taken ? bpu_pkg::strong_taken
                                            : bpu_pkg::weak_not_taken;
            end
            default: begin
                next_counter = update.taken ? bpu_pkg::strong_taken
                                            : bpu_pkg::weak_taken;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                counters[i] <= bpu_pkg::weak_not_taken;
            end
        end else if (update.update_en) begin
            counters[upd_idx] <= next_counter;
        end
    end

    // back end must keep the training strobe defined
    assert property (@(posedge clk) disable iff (rst) !$isunknown(update.update_en));

endmodule

// File: source/btb.sv
`timescale 1ns/1ps

module btb #(
    parameter int BTB_ENTRIES = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  bpu_pkg::addr_t          pc,
    input  bpu_pkg::branch_update_t update,
    output bpu_pkg::addr_t          target,
    output logic                    hit
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    // everything above the index and the byte offset
    localparam int TAG_W = 30 - IDX_W;

    logic [BTB_ENTRIES-1:0] valid;
    logic [TAG_W-1:0]       tags    [BTB_ENTRIES];
    bpu_pkg::addr_t         targets [BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic             wr_en;

    //////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////

    assign rd_idx = pc[IDX_W+1:2];
    assign rd_tag = pc[31:IDX_W+2];

    assign hit    = valid[rd_idx] && (tags[rd_idx] == rd_tag);
    assign target = targets[rd_idx];

    //////////////////////////////////////////////////
    // training
    //////////////////////////////////////////////////

    assign wr_idx = update.pc[IDX_W+1:2];
    assign wr_tag = update.pc[31:IDX_W+2];
    // not-taken branches never allocate
    assign wr_en  = update.update_en && update.taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[wr_idx]    <= wr_tag;
            targets[wr_idx] <= update.target;
        end
    end

    // buffer comes out of reset empty
    assert property (@(posedge clk) rst |=> !hit);

endmodule

// File: source/bpu.sv
`timescale 1ns/1ps

module bpu #(
    parameter int BHT_ENTRIES = 64,
    parameter int BTB_ENTRIES = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  bpu_pkg::addr_t          pc,
    input  bpu_pkg::inst_t          inst_1,
    input  bpu_pkg::inst_t          inst_2,
    input  logic                    inst_en_1,
    input  logic                    inst_en_2,
    input  bpu_pkg::branch_update_t update,
    output bpu_pkg::prediction_t    prediction
);

    bpu_pkg::opcode_t opcode_1;
    bpu_pkg::opcode_t opcode_2;
    logic             is_branch_1;
    logic             is_branch_2;
    logic             bht_taken;
    logic             btb_hit;
    bpu_pkg::addr_t   btb_target;
    logic             pred_taken;
    logic             last_taken;

    // true for the contiguous branch opcode range
    function automatic logic is_branch_op(bpu_pkg::opcode_t op);
        return (op >= bpu_pkg::branch_opcode_lo) && (op <= bpu_pkg::branch_opcode_hi);
    endfunction

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    assign opcode_1 = inst_1[31:26];
    assign opcode_2 = inst_2[31:26];

    assign is_branch_1 = is_branch_op(opcode_1);
    assign is_branch_2 = is_branch_op(opcode_2);

    //////////////////////////////////////////////////
    // direction and target
    //////////////////////////////////////////////////

    bht #(
        .BHT_ENTRIES(BHT_ENTRIES)
    ) bht_i (
        .clk    (clk),
        .rst    (rst),
        .pc     (pc),
        .update (update),
        .taken  (bht_taken)
    );

    btb #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) btb_i (
        .clk    (clk),
        .rst    (rst),
        .pc     (pc),
        .update (update),
        .target (btb_target),
        .hit    (btb_hit)
    );

    // only slot 1 is ever predicted, and only with a btb hit
    assign pred_taken = is_branch_1 && inst_en_1 && bht_taken && btb_hit;

    always_comb begin
        prediction.is_branch_1 = is_branch_1;
        prediction.is_branch_2 = is_branch_2;
        prediction.taken       = pred_taken;
        prediction.target      = pred_taken ? btb_target : '0;
        // slot 2 lies past a taken slot 1 branch
        prediction.slot_2_en   = pred_taken ? 1'b0 : inst_en_2;
        prediction.valid_in    = !last_taken;
    end

    // packet fetched right after a taken redirect is a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            last_taken <= 1'b0;
        end else if (!stall) begin
            last_taken <= pred_taken;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        prediction.taken |-> prediction.is_branch_1);

endmodule

// File: source/fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen #(
    parameter bpu_pkg::addr_t RESET_PC = 32'h1c00_0000
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  bpu_pkg::branch_update_t update,
    input  logic                    taken,
    input  bpu_pkg::addr_t          target,
    output bpu_pkg::addr_t          pc
);

    bpu_pkg::addr_t pc_next;

    //////////////////////////////////////////////////
    // next fetch address
    //////////////////////////////////////////////////

    // flush beats stall, stall beats prediction
    always_comb begin
        if (update.flush) begin
            pc_next = update.target;
        end else if (stall) begin
            pc_next = pc;
        end else if (taken) begin
            pc_next = target;
        end else begin
            // two instructions per packet
            pc_next = pc + 32'd8;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // redirect and btb targets must be word addresses
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// File: source/fetch_predict_unit.sv
`timescale 1ns/1ps

module fetch_predict_unit #(
    parameter int             BHT_ENTRIES = 64,
    parameter int             BTB_ENTRIES = 32,
    parameter bpu_pkg::addr_t RESET_PC    = 32'h1c00_0000
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  bpu_pkg::inst_t          inst_1,
    input  bpu_pkg::inst_t          inst_2,
    input  logic                    inst_en_1,
    input  logic                    inst_en_2,
    input  bpu_pkg::branch_update_t update,
    output bpu_pkg::addr_t          pc,
    output bpu_pkg::prediction_t    prediction
);

    fetch_pc_gen #(
        .RESET_PC(RESET_PC)
    ) fetch_pc_gen_i (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .update (update),
        .taken  (prediction.taken),
        .target (prediction.target),
        .pc     (pc)
    );

    // prediction works on the packet at the current pc
    bpu #(
        .BHT_ENTRIES(BHT_ENTRIES),
        .BTB_ENTRIES(BTB_ENTRIES)
    ) bpu_i (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .pc         (pc),
        .inst_1     (inst_1),
        .inst_2     (inst_2),
        .inst_en_1  (inst_en_1),
        .inst_en_2  (inst_en_2),
        .update     (update),
        .prediction (prediction)
    );

endmodule

// File: verification/tb_fetch_tasks.svh
// any word with a primary opcode inside the branch range
localparam bpu_pkg::inst_t BRANCH_WORD = {6'h16, 26'h000_0123};

bpu_pkg::addr_t branch_pc;
bpu_pkg::addr_t branch_target;

//////////////////////////////////////////////////
// helpers
//////////////////////////////////////////////////

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    assert (got === expected) else begin
        $display("error: %s = 0x%h, expected 0x%h", name, got, expected);
        abort_run();
    end
endtask

// drive 1 ns after the edge and sample 1 ns later
task automatic next_cycle(input bpu_pkg::branch_update_t upd, input logic stall_v);
    @(posedge clk);
    #1;
    drive_inputs(upd, stall_v);
    #1;
endtask

task automatic apply_reset();
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    drive_inputs('0, 1'b0);
    #1;
endtask

task automatic step_until(input bpu_pkg::addr_t target_pc);
    int n;
    n = 0;
    while (pc !== target_pc && n < 32) begin
        next_cycle('0, 1'b0);
        n++;
    end
    assert (pc === target_pc) else begin
        $display("fetch pc never reached 0x%h within 32 cycles", target_pc);
        abort_run();
    end
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////

task automatic sequential_fetch();
    bpu_pkg::addr_t exp_pc;
    exp_pc = RESET_PC;
    check_value("pc", pc, exp_pc);
    check_value("valid_in", prediction.valid_in, 1'b1);
    check_value("taken", prediction.taken, 1'b0);
    for (int i = 0; i < 4; i++) begin
        next_cycle('0, 1'b0);
        exp_pc = exp_pc + 32'd8;
        check_value("pc", pc, exp_pc);
    end
    // stall takes effect at the following edge
    next_cycle('0, 1'b1);
    exp_pc = exp_pc + 32'd8;
    check_value("pc", pc, exp_pc);
    next_cycle('0, 1'b1);
    check_value("pc", pc, exp_pc);
    next_cycle('0, 1'b0);
    check_value("pc", pc, exp_pc);
    next_cycle('0, 1'b0);
    exp_pc = exp_pc + 32'd8;
    check_value("pc", pc, exp_pc);
endtask

task automatic opcode_decode();
    logic [5:0] op;
    logic       in_range;
    override_en = 1'b1;
    for (int slot = 1; slot <= 2; slot++) begin
        for (int i = 0; i < 64; i++) begin
            op            = i[5:0];
            in_range      = (op >= 6'h12) && (op <= 6'h1b);
            override_pc   = (slot == 1) ? pc + 32'd8 : pc + 32'd12;
            override_word = {op, 26'h0};
            next_cycle('0, 1'b0);
            check_value("is_branch_1", prediction.is_branch_1, (slot == 1) && in_range);
            check_value("is_branch_2", prediction.is_branch_2, (slot == 2) && in_range);
        end
    end
    override_en = 1'b0;
endtask

// update field order is update_en, flush, pc, taken, target
task automatic taken_redirect();
    branch_pc     = pc + 32'd48;
    branch_target = 32'h1c00_4000;
    override_en   = 1'b1;
    override_pc   = branch_pc;
    override_word = BRANCH_WORD;
    next_cycle({1'b1, 1'b0, branch_pc, 1'b1, branch_target}, 1'b0);
    step_until(branch_pc);
    check_value("is_branch_1", prediction.is_branch_1, 1'b1);
    check_value("taken", prediction.taken, 1'b1);
    check_value("target", prediction.target, branch_target);
    check_value("slot_2_en", prediction.slot_2_en, 1'b0);
    next_cycle('0, 1'b0);
    check_value("pc", pc, branch_target);
    check_value("valid_in", prediction.valid_in, 1'b0);
    next_cycle('0, 1'b0);
    check_value("pc", pc, branch_target + 32'd8);
    check_value("valid_in", prediction.valid_in, 1'b1);
endtask

task automatic decay_and_tag_miss();
    bpu_pkg::addr_t alias_pc;
    // weak_taken down to strong_not_taken
    next_cycle({1'b1, 1'b0, branch_pc, 1'b0, branch_target}, 1'b0);
    next_cycle({1'b1, 1'b0, branch_pc, 1'b0, branch_target}, 1'b0);
    next_cycle({1'b0, 1'b1, 32'h0, 1'b0, branch_pc - 32'd16}, 1'b0);
    step_until(branch_pc);
    check_value("taken", prediction.taken, 1'b0);
    check_value("target", prediction.target, 32'h0);
    check_value("slot_2_en", prediction.slot_2_en, 1'b1);
    next_cycle('0, 1'b0);
    check_value("pc", pc, branch_pc + 32'd8);
    // same bht and btb index but a tag that differs in bit 8
    alias_pc = branch_pc + 32'h100;
    next_cycle({1'b1, 1'b0, branch_pc, 1'b1, branch_target}, 1'b0);
    next_cycle({1'b1, 1'b0, branch_pc, 1'b1, branch_target}, 1'b0);
    next_cycle({1'b0, 1'b1, 32'h0, 1'b0, alias_pc - 32'd8}, 1'b0);
    override_pc = alias_pc;
    step_until(alias_pc);
    check_value("is_branch_1", prediction.is_branch_1, 1'b1);
    check_value("taken", prediction.taken, 1'b0);
    next_cycle('0, 1'b0);
    check_value("pc", pc, alias_pc + 32'd8);
endtask

task automatic flush_priority();
    bpu_pkg::addr_t flush_pc;
    flush_pc    = 32'h1c00_8000;
    override_pc = branch_pc;
    next_cycle({1'b0, 1'b1, 32'h0, 1'b0, branch_pc}, 1'b0);
    // flush, stall and a taken prediction all in one cycle
    next_cycle({1'b0, 1'b1, 32'h0, 1'b0, flush_pc}, 1'b1);
    check_value("pc", pc, branch_pc);
    check_value("taken", prediction.taken, 1'b1);
    check_value("target", prediction.target, branch_target);
    next_cycle('0, 1'b0);
    check_value("pc", pc, flush_pc);
    check_value("valid_in", prediction.valid_in, 1'b1);
    override_en = 1'b0;
endtask

// File: verification/tb_fetch_predict.sv
`timescale 1ns/1ps

module tb_fetch_predict;

    localparam bpu_pkg::addr_t RESET_PC = 32'h1c00_0000;
    // full sequence needs a little under 200 cycles
    localparam int MAX_CYCLES = 600;

    logic                    clk;
    logic                    rst;
    logic                    stall;
    bpu_pkg::inst_t          inst_1;
    bpu_pkg::inst_t          inst_2;
    logic                    inst_en_1;
    logic                    inst_en_2;
    bpu_pkg::branch_update_t update;
    bpu_pkg::addr_t          pc;
    bpu_pkg::prediction_t    prediction;

    integer         seed;
    int             cycles;
    int             fail_count;
    // one word the running test places in memory
    logic           override_en;
    bpu_pkg::addr_t override_pc;
    bpu_pkg::inst_t override_word;

    fetch_predict_unit fetch_predict_unit_i (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .inst_1     (inst_1),
        .inst_2     (inst_2),
        .inst_en_1  (inst_en_1),
        .inst_en_2  (inst_en_2),
        .update     (update),
        .pc         (pc),
        .prediction (prediction)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        fail_count = fail_count + 1;
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////
    // instruction memory model
    //////////////////////////////////////////////////

    function automatic bpu_pkg::inst_t fetch_word(bpu_pkg::addr_t addr);
        logic [31:0] r;
        logic [5:0]  op;
        if (override_en && addr == override_pc) begin
            return override_word;
        end
        r  = $random(seed);
        op = r[31:26];
        // push branch opcodes out of the 0x12..0x1b window
        if (op >= 6'h12 && op <= 6'h1b) begin
            op = op + 6'd10;
        end
        return {op, r[25:0]};
    endfunction

    task automatic drive_inputs(input bpu_pkg::branch_update_t upd, input logic stall_v);
        update    = upd;
        stall     = stall_v;
        inst_1    = fetch_word(pc);
        inst_2    = fetch_word(pc + 32'd4);
        inst_en_1 = 1'b1;
        inst_en_2 = 1'b1;
    endtask

    `include "tb_fetch_tasks.svh"

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        stall         = 1'b0;
        inst_1        = '0;
        inst_2        = '0;
        inst_en_1     = 1'b0;
        inst_en_2     = 1'b0;
        update        = '0;
        seed          = 32'hb4c90ead;
        cycles        = 0;
        fail_count    = 0;
        override_en   = 1'b0;
        override_pc   = '0;
        override_word = '0;

        apply_reset();
        sequential_fetch();
        opcode_decode();
        taken_redirect();
        decay_and_tag_miss();
        flush_priority();

        if (fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

endmodule

// File: build.f
+incdir+verification
source/bpu_pkg.sv
source/bht.sv
source/btb.sv
source/bpu.sv
source/fetch_pc_gen.sv
source/fetch_predict_unit.sv
verification/tb_fetch_predict.sv

// File: Bender.yml
package:
  name: fetch_predict_unit

sources:
  - source/bpu_pkg.sv
  - source/bht.sv
  - source/btb.sv
  - source/bpu.sv
  - source/fetch_pc_gen.sv
  - source/fetch_predict_unit.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_fetch_predict.sv
